/* rtl/tracking_cfg.svh */
`ifndef TRACKING_CFG_SVH
`define TRACKING_CFG_SVH

// Memory word and address widths
`define WORD_W 32
`define ADDR_W 18

// Widest blob count a request can carry
`define COUNT_W 16

// Colors known to the extraction stage, codes 1..NUM_COLORS
`define NUM_COLORS 6

// Address of record zero in the blob table
`define TABLE_BASE 200000

// Heights above this are treated as zero in highest mode
`define HEIGHT_LIMIT 120

`endif

/* rtl/blob_mem_pkg.sv */
`include "tracking_cfg.svh"

package blob_mem_pkg;

	typedef logic [`WORD_W-1:0] mem_word_t;
	typedef logic [`ADDR_W-1:0] mem_addr_t;

	typedef logic [7:0] color_code_t;    // Color index plus one, zero if unknown
	typedef logic [15:0] metric_t;       // Size, or height widened
	typedef logic [7:0] height_t;
	typedef logic [7:0] coord_t;
	typedef logic [15:0] centroid_sum_t;

	typedef struct packed {
		logic rd_en;
		mem_addr_t addr;
	} mem_rd_t;

	// Word 0 of a record
	typedef struct packed {
		logic [`WORD_W-9:0] spare;
		color_code_t code;
	} color_word_t;

	// Word 1 of a record
	typedef struct packed {
		logic [`WORD_W-25:0] spare;
		height_t height;
		metric_t size;
	} size_word_t;

	// Word 2 of a record
	typedef struct packed {
		coord_t x;
		coord_t y;
		centroid_sum_t sum;
	} centroid_word_t;

endpackage

/* rtl/tracking_pkg.sv */
`include "tracking_cfg.svh"

package tracking_pkg;
	import blob_mem_pkg::*;

	typedef logic [`COUNT_W-1:0] blob_count_t;
	typedef logic [2:0] color_idx_t;    // Color code minus one
	typedef logic [7:0] min_size_t;

	typedef enum logic {
		mode_biggest,    // Rank on size field
		mode_highest     // Rank on height field
	} metric_mode_t;

	typedef struct packed {
		blob_count_t blob_count;
		min_size_t min_size;
		metric_mode_t mode;
	} track_req_t;

	// One color's answer
	typedef struct packed {
		logic found;
		coord_t x;
		coord_t y;
		centroid_sum_t sum;
		metric_t metric;
	} slot_t;

	typedef slot_t [`NUM_COLORS-1:0] track_result_t;

	typedef enum logic [2:0] {
		st_idle,
		st_clear,
		st_read_color,
		st_read_metric,
		st_read_centroid,
		st_report
	} ctrl_state_t;

endpackage

/* rtl/tracking_ctrl.sv */
`timescale 1ns/1ps
`include "tracking_cfg.svh"

module tracking_ctrl import blob_mem_pkg::*, tracking_pkg::*; (
	input  logic        crystal_clk_div_by_two,
	input  logic        rst,
	input  logic        start_valid,
	input  track_req_t  start_req,
	output logic        start_ready,
	input  logic        result_ready,
	output logic        result_valid,
	output mem_rd_t     mem_rd,
	input  mem_word_t   mem_rdata,
	output logic        clear,
	output logic        color_strobe,
	output logic        metric_strobe,
	output blob_count_t rec_index,
	output color_idx_t  query_color,
	input  blob_count_t best_index,
	input  logic        best_found,
	output logic        capture,
	output color_idx_t  slot,
	output track_req_t  req
);

	ctrl_state_t state;
	logic wait_data;            // Read went out last cycle
	color_idx_t ext_color;      // Color being extracted
	color_word_t color_word;
	mem_addr_t rec_addr;
	mem_addr_t cent_addr;
	logic rec_done;
	logic last_rec;
	logic color_done;
	logic last_color;

	assign color_word = color_word_t'(mem_rdata);

	// Record n sits at base + 3n, centroid is its third word
	assign rec_addr = mem_addr_t'(`TABLE_BASE + 3 * rec_index);
	assign cent_addr = mem_addr_t'(`TABLE_BASE + 3 * best_index + 2);

	assign start_ready = (state == st_idle);
	assign clear = (state == st_clear);
	assign color_strobe = (state == st_read_color) && wait_data;
	assign metric_strobe = (state == st_read_metric) && wait_data;
	assign capture = (state == st_read_centroid) && wait_data && best_found;
	assign result_valid = (state == st_report);

	assign query_color = ext_color;
	assign slot = ext_color;

	// Unknown color ends the record early
	assign rec_done = (color_strobe && (color_word.code == '0)) || metric_strobe;
	assign last_rec = (rec_index == req.blob_count - 1'b1);
	assign color_done = (state == st_read_centroid) && wait_data;
	assign last_color = (ext_color == color_idx_t'(`NUM_COLORS - 1));

	always_comb begin
		mem_rd = '0;
		case (state)
			st_read_color: begin
				mem_rd.rd_en = !wait_data;
				mem_rd.addr = rec_addr;
			end
			st_read_metric: begin
				mem_rd.rd_en = !wait_data;
				mem_rd.addr = rec_addr + mem_addr_t'(1);
			end
			st_read_centroid: begin
				mem_rd.rd_en = !wait_data && best_found;    // Skip colors never seen
				mem_rd.addr = cent_addr;
			end
			default: begin
				mem_rd = '0;
			end
		endcase
	end

	always_ff @(posedge crystal_clk_div_by_two) begin
		if (rst) begin
			state <= st_idle;
			wait_data <= 1'b0;
		end else begin
			case (state)
				st_idle: begin
					if (start_valid) begin
						state <= st_clear;
					end
				end
				st_clear: begin
					wait_data <= 1'b0;
					state <= (req.blob_count == '0) ? st_read_centroid : st_read_color;
				end
				st_read_color, st_read_metric: begin
					wait_data <= !wait_data;    // Issue, then take data
					if (rec_done) begin
						state <= last_rec ? st_read_centroid : st_read_color;
					end else if (color_strobe) begin
						state <= st_read_metric;
					end
				end
				st_read_centroid: begin
					wait_data <= !wait_data;    // Two cycles per color
					if (color_done && last_color) begin
						state <= st_report;
					end
				end
				st_report: begin
					if (result_ready) begin
						state <= st_idle;
					end
				end
				default: begin
					state <= st_idle;
				end
			endcase
		end
	end

	always_ff @(posedge crystal_clk_div_by_two) begin
		if (start_ready && start_valid) begin
			req <= start_req;
		end
		if (clear) begin
			rec_index <= '0;
		end else if (rec_done) begin
			rec_index <= rec_index + 1'b1;
		end
		if (clear) begin
			ext_color <= '0;
		end else if (color_done) begin
			ext_color <= ext_color + 1'b1;
		end
	end

endmodule

/* rtl/blob_ranker.sv */
`timescale 1ns/1ps
`include "tracking_cfg.svh"

module blob_ranker import blob_mem_pkg::*, tracking_pkg::*; (
	input  logic        crystal_clk_div_by_two,
	input  logic        clear,
	input  logic        color_strobe,
	input  logic        metric_strobe,
	input  mem_word_t   mem_rdata,
	input  blob_count_t rec_index,
	input  track_req_t  req,
	input  color_idx_t  query_color,
	output blob_count_t best_index,
	output logic        best_found,
	output metric_t     best_metric
);

	color_word_t color_word;
	size_word_t size_word;
	color_idx_t cur_color;     // Color of the record in flight
	logic cur_known;
	metric_t metric;
	logic qualifies;
	logic beats;

	metric_t best_metric_tab [`NUM_COLORS];
	blob_count_t best_index_tab [`NUM_COLORS];
	logic [`NUM_COLORS-1:0] found_tab;

	assign color_word = color_word_t'(mem_rdata);
	assign size_word = size_word_t'(mem_rdata);

	// Codes are stored offset by one
	always_ff @(posedge crystal_clk_div_by_two) begin
		if (color_strobe) begin
			cur_color <= color_idx_t'(color_word.code - 1'b1);
			cur_known <= (color_word.code != '0) && (color_word.code <= `NUM_COLORS);
		end
	end

	always_comb begin
		if (req.mode == mode_biggest) begin
			metric = size_word.size;
		end else if (size_word.height > `HEIGHT_LIMIT) begin
			metric = '0;    // Out of frame
		end else begin
			metric = metric_t'(size_word.height);
		end
	end

	assign qualifies = cur_known && (metric > metric_t'(req.min_size));
	// Strictly greater, so a tie keeps the earlier record
	assign beats = !found_tab[cur_color] || (metric > best_metric_tab[cur_color]);

	always_ff @(posedge crystal_clk_div_by_two) begin
		if (clear) begin
			found_tab <= '0;
		end else if (metric_strobe && qualifies && beats) begin
			found_tab[cur_color] <= 1'b1;
			best_metric_tab[cur_color] <= metric;
			best_index_tab[cur_color] <= rec_index;
		end
	end

	assign best_index = best_index_tab[query_color];
	assign best_found = found_tab[query_color];
	assign best_metric = best_metric_tab[query_color];

endmodule

/* rtl/centroid_collector.sv */
`timescale 1ns/1ps

module centroid_collector import blob_mem_pkg::*, tracking_pkg::*; (
	input  logic          crystal_clk_div_by_two,
	input  logic          clear,
	input  logic          capture,
	input  color_idx_t    slot,
	input  mem_word_t     mem_rdata,
	input  metric_t       best_metric,
	input  logic          best_found,
	output track_result_t result
);

	centroid_word_t cent;
	slot_t entry;

	assign cent = centroid_word_t'(mem_rdata);

	// Word 2 split into its fields
	always_comb begin
		entry.found = best_found;
		entry.x = cent.x;
		entry.y = cent.y;
		entry.sum = cent.sum;
		entry.metric = best_metric;    // Held by the ranker for this color
	end

	always_ff @(posedge crystal_clk_div_by_two) begin
		if (clear) begin
			result <= '0;    // Unfound colors read as zero
		end else if (capture) begin
			result[slot] <= entry;
		end
	end

endmodule

/* rtl/tracking_top.sv */
`timescale 1ns/1ps

module tracking_top import blob_mem_pkg::*, tracking_pkg::*; (
	input  logic          crystal_clk_div_by_two,
	input  logic          rst,
	input  logic          start_valid,
	input  track_req_t    start_req,
	output logic          start_ready,
	output mem_rd_t       mem_rd,
	input  mem_word_t     mem_rdata,
	output logic          result_valid,
	output track_result_t result,
	input  logic          result_ready
);

	logic clear;
	logic color_strobe;
	logic metric_strobe;
	logic capture;
	logic best_found;
	blob_count_t rec_index;
	blob_count_t best_index;
	color_idx_t query_color;
	color_idx_t slot;
	metric_t best_metric;
	track_req_t req;    // Request held for the run

	tracking_ctrl u_ctrl (
		.crystal_clk_div_by_two(crystal_clk_div_by_two),
		.rst(rst),
		.start_valid(start_valid),
		.start_req(start_req),
		.start_ready(start_ready),
		.result_ready(result_ready),
		.result_valid(result_valid),
		.mem_rd(mem_rd),
		.mem_rdata(mem_rdata),
		.clear(clear),
		.color_strobe(color_strobe),
		.metric_strobe(metric_strobe),
		.rec_index(rec_index),
		.query_color(query_color),
		.best_index(best_index),
		.best_found(best_found),
		.capture(capture),
		.slot(slot),
		.req(req)
	);

	blob_ranker u_ranker (
		.crystal_clk_div_by_two(crystal_clk_div_by_two),
		.clear(clear),
		.color_strobe(color_strobe),
		.metric_strobe(metric_strobe),
		.mem_rdata(mem_rdata),
		.rec_index(rec_index),
		.req(req),
		.query_color(query_color),
		.best_index(best_index),
		.best_found(best_found),
		.best_metric(best_metric)
	);

	centroid_collector u_collector (
		.crystal_clk_div_by_two(crystal_clk_div_by_two),
		.clear(clear),
		.capture(capture),
		.slot(slot),
		.mem_rdata(mem_rdata),
		.best_metric(best_metric),
		.best_found(best_found),
		.result(result)
	);

endmodule

/* bench/tracking_checker.sv */
`timescale 1ns/1ps
`include "tracking_cfg.svh"

module tracking_checker import blob_mem_pkg::*, tracking_pkg::*; #(
	parameter int TABLE_WORDS = 120
) (
	input logic          crystal_clk_div_by_two,
	input logic          rst,
	input logic          start_valid,
	input track_req_t    start_req,
	input logic          start_ready,
	input mem_rd_t       mem_rd,
	input logic          result_valid,
	input track_result_t result,
	input logic          result_ready
);

	mem_word_t tbl [TABLE_WORDS];
	track_req_t req;
	track_result_t expected;
	track_result_t held;    // Result seen on the previous cycle
	logic held_ok = 1'b0;
	logic in_run = 1'b0;
	logic reset_checked = 1'b0;
	int run_errs = 0;
	int err_count = 0;
	int check_count = 0;
	int run_count = 0;

	task automatic load_word(int idx, mem_word_t word);
		tbl[idx] = word;
	endtask

	// Best qualifying record per color, earlier record kept on a tie
	function automatic track_result_t predict(track_req_t r);
		track_result_t res;
		int best_rec [`NUM_COLORS];
		int best_val [`NUM_COLORS];
		int code;
		int m;
		int w;
		res = '0;
		for (int c = 0; c < `NUM_COLORS; c++) begin
			best_rec[c] = -1;
			best_val[c] = 0;
		end
		for (int n = 0; n < int'(r.blob_count); n++) begin
			code = int'(tbl[3*n][7:0]);
			if (r.mode == mode_biggest) begin
				m = int'(tbl[3*n+1][15:0]);
			end else begin
				m = int'(tbl[3*n+1][23:16]);
				if (m > `HEIGHT_LIMIT) m = 0;
			end
			if (code >= 1 && code <= `NUM_COLORS && m > int'(r.min_size)) begin
				if (best_rec[code-1] < 0 || m > best_val[code-1]) begin
					best_rec[code-1] = n;
					best_val[code-1] = m;
				end
			end
		end
		for (int c = 0; c < `NUM_COLORS; c++) begin
			if (best_rec[c] >= 0) begin
				w = 3 * best_rec[c] + 2;
				res[c].found = 1'b1;
				res[c].x = tbl[w][31:24];
				res[c].y = tbl[w][23:16];
				res[c].sum = tbl[w][15:0];
				res[c].metric = 16'(best_val[c]);
			end
		end
		return res;
	endfunction

	task automatic check_value(string name, int exp_val, int act_val);
		check_count++;
		if (exp_val != act_val) begin
			$display("Error at %0t: %s expected 0x%0h actual 0x%0h", $time, name, exp_val,
				act_val);
			run_errs++;
			err_count++;
		end
	endtask

	task automatic compare_result();
		string where;
		for (int c = 0; c < `NUM_COLORS; c++) begin
			where = $sformatf("result[%0d]", c);
			check_value({where, ".found"}, expected[c].found, result[c].found);
			check_value({where, ".x"}, expected[c].x, result[c].x);
			check_value({where, ".y"}, expected[c].y, result[c].y);
			check_value({where, ".sum"}, expected[c].sum, result[c].sum);
			check_value({where, ".metric"}, expected[c].metric, result[c].metric);
		end
		$display("run %0d (%s, %0d blobs, min %0d): %0d errors", run_count,
			(req.mode == mode_biggest) ? "biggest" : "highest", req.blob_count,
			req.min_size, run_errs);
		run_count++;
	endtask

	always @(negedge crystal_clk_div_by_two) begin
		if (!rst) begin
			if (!reset_checked) begin
				run_errs = 0;
				check_value("start_ready", 1, start_ready);
				check_value("result_valid", 0, result_valid);
				check_value("mem_rd.rd_en", 0, mem_rd.rd_en);
				$display("reset state: %0d errors", run_errs);
				reset_checked = 1'b1;
			end
			if (start_valid && start_ready) begin
				if (in_run) begin
					$display("Request accepted at %0t before the last result was taken", $time);
					err_count++;
				end
				req = start_req;
				expected = predict(start_req);
				in_run = 1'b1;
				run_errs = 0;
			end
			// Reads stay inside the scanned records
			if (mem_rd.rd_en) begin
				check_count++;
				if (mem_rd.addr < `TABLE_BASE || mem_rd.addr >= `TABLE_BASE + 3 * req.blob_count) begin
					$display("Error at %0t: mem_rd.addr expected %0d to %0d actual %0d", $time,
						`TABLE_BASE, `TABLE_BASE + 3 * req.blob_count - 1, mem_rd.addr);
					run_errs++;
					err_count++;
				end
			end
			if (result_valid) begin
				check_count++;
				if (held_ok && result !== held) begin
					$display("Error at %0t: result expected 0x%0h actual 0x%0h", $time, held,
						result);
					run_errs++;
					err_count++;
				end
				check_value("start_ready", 0, start_ready);
				check_value("mem_rd.rd_en", 0, mem_rd.rd_en);
				held = result;
				held_ok = 1'b1;
				if (result_ready) begin
					compare_result();
					in_run = 1'b0;
					held_ok = 1'b0;
				end
			end else begin
				held_ok = 1'b0;
			end
		end
	end

endmodule

/* bench/tb_tracking.sv */
`timescale 1ns/1ps
`include "tracking_cfg.svh"

module tb_tracking import blob_mem_pkg::*, tracking_pkg::*;;

	localparam int NUM_RUNS = 12;
	localparam int MAX_RECS = 40;
	localparam int TABLE_WORDS = 3 * MAX_RECS;
	localparam int WAIT_LIMIT = 2000;    // Cycles, far above the longest run

	logic crystal_clk_div_by_two;
	logic rst;
	logic start_valid;
	track_req_t start_req;
	logic start_ready;
	mem_rd_t mem_rd;
	mem_word_t mem_rdata;
	logic result_valid;
	track_result_t result;
	logic result_ready;

	mem_word_t table_mem [TABLE_WORDS];
	logic rd_pending;
	mem_addr_t rd_addr;
	bit timed_out;

	tracking_top UUT (
		.crystal_clk_div_by_two(crystal_clk_div_by_two),
		.rst(rst),
		.start_valid(start_valid),
		.start_req(start_req),
		.start_ready(start_ready),
		.mem_rd(mem_rd),
		.mem_rdata(mem_rdata),
		.result_valid(result_valid),
		.result(result),
		.result_ready(result_ready)
	);

	tracking_checker #(.TABLE_WORDS(TABLE_WORDS)) u_check (
		.crystal_clk_div_by_two(crystal_clk_div_by_two),
		.rst(rst),
		.start_valid(start_valid),
		.start_req(start_req),
		.start_ready(start_ready),
		.mem_rd(mem_rd),
		.result_valid(result_valid),
		.result(result),
		.result_ready(result_ready)
	);

	always #50 crystal_clk_div_by_two = ~crystal_clk_div_by_two;

	function automatic mem_word_t read_word(mem_addr_t addr);
		int offset;
		offset = int'(addr) - `TABLE_BASE;
		if (offset >= 0 && offset < TABLE_WORDS) begin
			return table_mem[offset];
		end
		return {addr[13:0], addr};    // Fill outside the table
	endfunction

	// Memory model with one cycle of read latency
	always @(negedge crystal_clk_div_by_two) begin
		rd_pending = !rst && mem_rd.rd_en;
		rd_addr = mem_rd.addr;
	end

	always @(posedge crystal_clk_div_by_two) begin
		#1;
		if (rd_pending) begin
			mem_rdata = read_word(rd_addr);
		end
	end

	task automatic next_drive_point();
		@(posedge crystal_clk_div_by_two);
		#1;
	endtask

	task automatic wait_start_ready();
		int cycles;
		cycles = 0;
		do begin
			@(negedge crystal_clk_div_by_two);
			cycles++;
		end while (!start_ready && cycles < WAIT_LIMIT);
		if (!start_ready) begin
			$display("Timeout: start_ready stayed low for %0d cycles", WAIT_LIMIT);
			timed_out = 1'b1;
		end
	endtask

	task automatic wait_result_valid();
		int cycles;
		cycles = 0;
		do begin
			@(negedge crystal_clk_div_by_two);
			cycles++;
		end while (!result_valid && cycles < WAIT_LIMIT);
		if (!result_valid) begin
			$display("Timeout: no result within %0d cycles", WAIT_LIMIT);
			timed_out = 1'b1;
		end
	endtask

	task automatic fill_table();
		logic [15:0] size;
		for (int n = 0; n < MAX_RECS; n++) begin
			case ($urandom % 4)
				0: size = 16'($urandom % 300);        // Around the minimum
				1: size = 16'(600 + $urandom % 3);    // Ties likely
				default: size = 16'($urandom);
			endcase
			table_mem[3*n] = mem_word_t'($urandom % 8);
			table_mem[3*n+1] = {8'($urandom), 8'($urandom), size};
			table_mem[3*n+2] = $urandom;
		end
		for (int i = 0; i < TABLE_WORDS; i++) begin
			u_check.load_word(i, table_mem[i]);
		end
	endtask

	task automatic run_one(int run);
		track_req_t req;
		int hold;
		req.mode = metric_mode_t'($urandom % 2);
		req.blob_count = (run == 1) ? '0 : blob_count_t'(1 + $urandom % MAX_RECS);
		req.min_size = (req.mode == mode_highest) ? 8'($urandom % 100) : 8'($urandom);
		hold = $urandom % 6;
		wait_start_ready();
		if (timed_out) return;
		fill_table();
		next_drive_point();
		start_valid = 1'b1;
		start_req = req;
		result_ready = (hold == 0);    // No back-pressure on this run
		wait_start_ready();
		next_drive_point();
		start_valid = 1'b0;
		wait_result_valid();
		if (timed_out) return;
		if (hold > 0) begin
			next_drive_point();
			start_valid = 1'b1;    // Must not be taken while the result waits
			start_req = track_req_t'($urandom);
			repeat (hold) next_drive_point();
			start_valid = 1'b0;
			result_ready = 1'b1;
			wait_result_valid();
		end
		next_drive_point();
		result_ready = 1'b0;
	endtask

	initial begin
		crystal_clk_div_by_two = 1'b0;
		rst = 1'b1;
		start_valid = 1'b0;
		start_req = '0;
		result_ready = 1'b0;
		mem_rdata = '0;
		rd_pending = 1'b0;
		rd_addr = '0;
		timed_out = 1'b0;
		void'($urandom(49));
		repeat (5) @(posedge crystal_clk_div_by_two);
		#1;
		rst = 1'b0;
		for (int run = 0; run < NUM_RUNS && !timed_out; run++) begin
			run_one(run);
		end
		next_drive_point();
		$display("%0d runs, %0d checks, %0d errors", u_check.run_count,
			u_check.check_count, u_check.err_count);
		if (!timed_out && u_check.err_count == 0 && u_check.run_count == NUM_RUNS) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

/* tb.f */
+incdir+rtl
rtl/blob_mem_pkg.sv
rtl/tracking_pkg.sv
rtl/tracking_ctrl.sv
rtl/blob_ranker.sv
rtl/centroid_collector.sv
rtl/tracking_top.sv
bench/tracking_checker.sv
bench/tb_tracking.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_tracking
FILELIST ?= tb.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall
PASS_MSG ?= *** PASSED ***

SOURCES := $(wildcard rtl/*.sv rtl/*.svh bench/*.sv)

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF '$(PASS_MSG)' $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
